//--- src/serial_link_macros.svh
////////////////////////////////////////////////////////////////////////////
// Serial link sizing
// Lane count, payload width, credit depth and flit pacing shared by the
// package, the data link and the physical layer
////////////////////////////////////////////////////////////////////////////

`ifndef SERIAL_LINK_MACROS_SVH
`define SERIAL_LINK_MACROS_SVH

// Lanes per channel, also the flit width
`define SL_NUM_LANES 8

// One user payload
`define SL_PAYLOAD_BITS 32

// Receive buffer entries and initial send credits
`define SL_NUM_CREDITS 4
`define SL_CREDIT_BITS 3

// Flits per packet, ceil(37 / 8)
`define SL_FLITS 5

// Clock cycles between two flits on the lanes
`define SL_CYCLES_PER_FLIT 4

`endif

//--- src/serial_link_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Serial link types
// Header tags, credit counts, payloads, packets and lane-wide flits
////////////////////////////////////////////////////////////////////////////

`include "serial_link_macros.svh"

package serial_link_pkg;

  // Header tag, the two remaining codes are invalid and get dropped
  typedef enum logic [1:0] {
    TAG_DATA   = 2'b01,
    TAG_CREDIT = 2'b10
  } tag_e;

  typedef logic [`SL_CREDIT_BITS-1:0] credit_t;

  typedef logic [`SL_PAYLOAD_BITS-1:0] payload_t;

  // Payload sits in the low bits and leaves with the first flit
  typedef struct packed {
    tag_e     tag;
    credit_t  credit;
    payload_t payload;
  } packet_t;

  typedef logic [`SL_NUM_LANES-1:0] flit_t;

endpackage

//--- src/serial_link_stream_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Stream FIFO
// Valid/ready circular buffer for any payload type, with bypass when
// empty and simultaneous push and pop when full
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module serial_link_stream_fifo #(
  parameter type data_t = logic,
  parameter int  Depth  = 2
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  push_valid_i,
  input  data_t push_data_i,
  output logic  push_ready_o,
  output logic  pop_valid_o,
  output data_t pop_data_o,
  input  logic  pop_ready_i
);

  localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntBits = $clog2(Depth + 1);

  data_t              mem_q [Depth];
  logic [PtrBits-1:0] wr_ptr_q;
  logic [PtrBits-1:0] rd_ptr_q;
  logic [CntBits-1:0] count_q;
  logic               empty;
  logic               full;
  logic               push;
  logic               pop;

  assign empty = (count_q == '0);
  assign full  = (count_q == CntBits'(Depth));

  // A full buffer refills the slot its head frees in the same cycle
  assign push_ready_o = !full || pop_ready_i;
  // Empty buffer forwards the incoming entry straight through
  assign pop_valid_o  = !empty || push_valid_i;
  assign pop_data_o   = empty ? push_data_i : mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrBits'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrBits'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // A push taken on a full buffer would lift the fill count past the depth
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CntBits'(Depth))
    else $error("stream fifo: push accepted while full");

endmodule

//--- src/serial_link_credit_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Credit control
// Tracks credits available for sending and freed receive entries still
// waiting to be returned to the far end
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "serial_link_macros.svh"

module serial_link_credit_ctrl import serial_link_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    send_take_i,
  input  logic    credit_in_valid_i,
  input  credit_t credit_in_i,
  input  logic    return_add_i,
  input  logic    return_taken_i,
  output logic    send_avail_o,
  output credit_t return_pending_o
);

  credit_t send_q;
  credit_t send_d;
  credit_t return_q;
  credit_t return_d;

  always_comb begin
    send_d = send_q;
    if (send_take_i) begin
      send_d = send_d - 1'b1;
    end
    if (credit_in_valid_i) begin
      send_d = send_d + credit_in_i;
    end
  end

  // Returns carried out this cycle are dropped, a pop in the same cycle counts anew
  always_comb begin
    return_d = return_taken_i ? '0 : return_q;
    if (return_add_i) begin
      return_d = return_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      send_q   <= credit_t'(`SL_NUM_CREDITS);
      return_q <= '0;
    end else begin
      send_q   <= send_d;
      return_q <= return_d;
    end
  end

  assign send_avail_o     = (send_q != '0);
  assign return_pending_o = return_q;

  // Far end never hands back more than the receive buffer holds
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    send_q <= credit_t'(`SL_NUM_CREDITS))
    else $error("credit ctrl: send credits above buffer depth");

endmodule

//--- src/serial_link_data_link.sv
////////////////////////////////////////////////////////////////////////////
// Serial link data link layer
// Wraps payloads into tagged packets with returned credits, cuts them into
// flits, rebuilds received packets and buffers their payloads
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "serial_link_macros.svh"

module serial_link_data_link import serial_link_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i,
  output logic     flit_tx_valid_o,
  output flit_t    flit_tx_data_o,
  input  logic     flit_tx_ready_i,
  input  logic     flit_rx_valid_i,
  input  flit_t    flit_rx_data_i
);

  localparam int FrameBits = `SL_FLITS * `SL_NUM_LANES;
  localparam int IdxBits   = $clog2(`SL_FLITS);

  logic                 send_avail;
  credit_t              return_pending;
  packet_t              hold_push_data;
  logic                 hold_push_ready;
  logic                 hold_pop_valid;
  logic                 hold_pop_ready;
  packet_t              hold_pop_data;
  logic                 load_data;
  logic                 load_credit;
  packet_t              tx_pkt;
  logic                 tx_busy_q;
  logic [IdxBits-1:0]   tx_idx_q;
  logic [FrameBits-1:0] tx_frame_q;
  logic [FrameBits-1:0] rx_frame_q;
  logic [IdxBits-1:0]   rx_idx_q;
  logic                 rx_done_q;
  packet_t              rx_pkt;
  logic                 rx_push_valid;
  logic                 rx_push_ready;
  logic                 credit_in_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit side

  assign hold_push_data = '{tag: TAG_DATA, credit: '0, payload: in_data_i};
  assign in_ready_o     = send_avail && hold_push_ready;
  assign hold_pop_ready = !tx_busy_q && send_avail;

  serial_link_stream_fifo #(
    .data_t (packet_t),
    .Depth  (2)
  ) i_tx_hold_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_valid_i (in_valid_i && send_avail),
    .push_data_i  (hold_push_data),
    .push_ready_o (hold_push_ready),
    .pop_valid_o  (hold_pop_valid),
    .pop_data_o   (hold_pop_data),
    .pop_ready_i  (hold_pop_ready)
  );

  // Data wins, a credit-only packet goes out when nothing can be sent
  assign load_data   = hold_pop_valid && hold_pop_ready;
  assign load_credit = !tx_busy_q && !load_data && (return_pending != '0);

  always_comb begin
    tx_pkt = '0;
    if (load_data) begin
      tx_pkt = hold_pop_data;
    end else begin
      tx_pkt.tag = TAG_CREDIT;
    end
    tx_pkt.credit = return_pending;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_busy_q <= 1'b0;
      tx_idx_q  <= '0;
    end else if (load_data || load_credit) begin
      tx_busy_q <= 1'b1;
      tx_idx_q  <= '0;
    end else if (flit_tx_valid_o && flit_tx_ready_i) begin
      tx_idx_q <= tx_idx_q + 1'b1;
      if (tx_idx_q == IdxBits'(`SL_FLITS - 1)) begin
        tx_busy_q <= 1'b0;
      end
    end
  end

  // Frame shifts down so the current slice always sits in the low bits
  always_ff @(posedge clk_i) begin
    if (load_data || load_credit) begin
      tx_frame_q <= FrameBits'(tx_pkt);
    end else if (flit_tx_valid_o && flit_tx_ready_i) begin
      tx_frame_q <= tx_frame_q >> `SL_NUM_LANES;
    end
  end

  assign flit_tx_valid_o = tx_busy_q;
  assign flit_tx_data_o  = tx_frame_q[`SL_NUM_LANES-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Receive side

  // First flit ends up in the lowest slice after SL_FLITS shifts
  always_ff @(posedge clk_i) begin
    if (flit_rx_valid_i) begin
      rx_frame_q <= {flit_rx_data_i, rx_frame_q[FrameBits-1:`SL_NUM_LANES]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_idx_q  <= '0;
      rx_done_q <= 1'b0;
    end else begin
      rx_done_q <= 1'b0;
      if (flit_rx_valid_i) begin
        if (rx_idx_q == IdxBits'(`SL_FLITS - 1)) begin
          rx_idx_q  <= '0;
          rx_done_q <= 1'b1;
        end else begin
          rx_idx_q <= rx_idx_q + 1'b1;
        end
      end
    end
  end

  assign rx_pkt          = packet_t'(rx_frame_q[$bits(packet_t)-1:0]);
  assign credit_in_valid = rx_done_q && (rx_pkt.tag == TAG_DATA || rx_pkt.tag == TAG_CREDIT);
  assign rx_push_valid   = rx_done_q && (rx_pkt.tag == TAG_DATA);

  serial_link_stream_fifo #(
    .data_t (payload_t),
    .Depth  (`SL_NUM_CREDITS)
  ) i_rx_buffer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_valid_i (rx_push_valid),
    .push_data_i  (rx_pkt.payload),
    .push_ready_o (rx_push_ready),
    .pop_valid_o  (out_valid_o),
    .pop_data_o   (out_data_o),
    .pop_ready_i  (out_ready_i)
  );

  serial_link_credit_ctrl i_credit_ctrl (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .send_take_i       (load_data),
    .credit_in_valid_i (credit_in_valid),
    .credit_in_i       (rx_pkt.credit),
    .return_add_i      (out_valid_o && out_ready_i),
    .return_taken_i    (load_data || load_credit),
    .send_avail_o      (send_avail),
    .return_pending_o  (return_pending)
  );

  // The far end's credits must keep it from overrunning the buffer
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_push_valid |-> rx_push_ready)
    else $error("data link: payload received while receive buffer full");

endmodule

//--- src/serial_link_physical.sv
////////////////////////////////////////////////////////////////////////////
// Serial link physical layer
// Paces outgoing flits onto the lanes with a one-cycle strobe and
// registers strobed flits coming in from the far end
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "serial_link_macros.svh"

module serial_link_physical import serial_link_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  flit_tx_valid_i,
  input  flit_t flit_tx_data_i,
  output logic  flit_tx_ready_o,
  output flit_t tx_data_o,
  output logic  tx_valid_o,
  input  flit_t rx_data_i,
  input  logic  rx_valid_i,
  output logic  flit_rx_valid_o,
  output flit_t flit_rx_data_o
);

  localparam int CntBits = $clog2(`SL_CYCLES_PER_FLIT + 1);

  logic [CntBits-1:0] pace_cnt_q;
  logic               tx_accept;

  // Idle once the previous flit has had its full slot on the lanes
  assign flit_tx_ready_o = (pace_cnt_q == '0);
  assign tx_accept       = flit_tx_valid_i && flit_tx_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pace_cnt_q <= '0;
      tx_valid_o <= 1'b0;
    end else begin
      tx_valid_o <= tx_accept;
      if (tx_accept) begin
        pace_cnt_q <= CntBits'(`SL_CYCLES_PER_FLIT - 1);
      end else if (pace_cnt_q != '0) begin
        pace_cnt_q <= pace_cnt_q - 1'b1;
      end
    end
  end

  // Lanes hold the flit for the whole slot
  always_ff @(posedge clk_i) begin
    if (tx_accept) begin
      tx_data_o <= flit_tx_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receiver, no back-pressure on the lanes

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      flit_rx_valid_o <= 1'b0;
    end else begin
      flit_rx_valid_o <= rx_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_valid_i) begin
      flit_rx_data_o <= rx_data_i;
    end
  end

  // While the pacer runs the data link keeps its flit waiting unchanged
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (flit_tx_valid_i && !flit_tx_ready_o) |=> (flit_tx_valid_i && $stable(flit_tx_data_i)))
    else $error("physical: flit changed while waiting for the pacer");

endmodule

//--- src/serial_link_top.sv
////////////////////////////////////////////////////////////////////////////
// Serial link top level
// Single-channel link from a payload stream to paced lanes and back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module serial_link_top import serial_link_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i,
  output flit_t    tx_data_o,
  output logic     tx_valid_o,
  input  flit_t    rx_data_i,
  input  logic     rx_valid_i
);

  logic  flit_tx_valid;
  flit_t flit_tx_data;
  logic  flit_tx_ready;
  logic  flit_rx_valid;
  flit_t flit_rx_data;

  serial_link_data_link i_data_link (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .in_valid_i      (in_valid_i),
    .in_data_i       (in_data_i),
    .in_ready_o      (in_ready_o),
    .out_valid_o     (out_valid_o),
    .out_data_o      (out_data_o),
    .out_ready_i     (out_ready_i),
    .flit_tx_valid_o (flit_tx_valid),
    .flit_tx_data_o  (flit_tx_data),
    .flit_tx_ready_i (flit_tx_ready),
    .flit_rx_valid_i (flit_rx_valid),
    .flit_rx_data_i  (flit_rx_data)
  );

  serial_link_physical i_physical (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flit_tx_valid_i (flit_tx_valid),
    .flit_tx_data_i  (flit_tx_data),
    .flit_tx_ready_o (flit_tx_ready),
    .tx_data_o       (tx_data_o),
    .tx_valid_o      (tx_valid_o),
    .rx_data_i       (rx_data_i),
    .rx_valid_i      (rx_valid_i),
    .flit_rx_valid_o (flit_rx_valid),
    .flit_rx_data_o  (flit_rx_data)
  );

endmodule

//--- verif/tb_clk_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// Free-running clock and a synchronous active-low reset pulse
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HalfPeriod  = 5,
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #HalfPeriod clk_o = ~clk_o;
    end
  end

  // Release lands just after an edge, like the rest of the stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- verif/tb_serial_link.sv
////////////////////////////////////////////////////////////////////////////
// Serial link testbench
// Loops the lanes back, sends payloads through the link and checks order,
// back-pressure, credit packets and flit counts with directed tests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "serial_link_macros.svh"

module tb_serial_link import serial_link_pkg::*; ();

  localparam int TimeoutCycles = 6000;
  localparam int QuietCycles   = 2 * `SL_FLITS * `SL_CYCLES_PER_FLIT;
  localparam int BurstLen      = 12;
  localparam int AcceptLimit   = 1000;
  localparam int HoldCycles    = 200;
  localparam int IdleCycles    = 300;
  localparam int BackLen       = `SL_NUM_CREDITS + 2;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  payload_t in_data;
  logic     in_ready;
  logic     out_valid;
  payload_t out_data;
  logic     out_ready;
  flit_t    lane_data;
  logic     lane_valid;

  int       seed = 32'h30e5_c367;
  payload_t exp_q[$];
  string    test_name = "init";
  int       mismatch_count = 0;
  int       error_count = 0;
  int       cycle_count = 0;
  int       pulse_count = 0;
  int       out_count = 0;
  int       pulse_base = 0;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  // Lanes looped back onto the receiver
  serial_link_top uut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_data_i   (in_data),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_data_o  (out_data),
    .out_ready_i (out_ready),
    .tx_data_o   (lane_data),
    .tx_valid_o  (lane_valid),
    .rx_data_i   (lane_data),
    .rx_valid_i  (lane_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Monitors and timeout

  always @(posedge clk) begin
    if (rst_n && lane_valid) begin
      pulse_count <= pulse_count + 1;
    end
  end

  // Scoreboard, every output transfer takes the oldest expected payload
  always @(posedge clk) begin
    payload_t exp_data;
    if (rst_n && out_valid && out_ready) begin
      out_count <= out_count + 1;
      if (exp_q.size() == 0) begin
        $display("ERROR %s: output %h appeared with no payload outstanding",
                 test_name, out_data);
        error_count++;
      end else begin
        exp_data = exp_q.pop_front();
        if (out_data !== exp_data) begin
          $display("MISMATCH %s: out_data expected %h, actual %h",
                   test_name, exp_data, out_data);
          mismatch_count++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("ERROR: run stopped after %0d cycles, stuck in %s", cycle_count, test_name);
      error_count++;
      print_counts();
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic print_counts();
    $display("Errors: %0d mismatches, %0d other", mismatch_count, error_count);
  endtask

  // Holds valid until the handshake, then queues the payload as expected
  task automatic send_payload(input payload_t data);
    in_valid = 1'b1;
    in_data  = data;
    while (!in_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    exp_q.push_back(data);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Waits until the lanes have been silent long enough for the link to be idle
  task automatic wait_quiet();
    int quiet;
    int last;
    quiet = 0;
    last  = pulse_count;
    while (quiet < QuietCycles) begin
      @(posedge clk);
      #1;
      if (pulse_count != last) begin
        quiet = 0;
        last  = pulse_count;
      end else begin
        quiet++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic test_reset();
    test_name = "test_reset";
    if (in_ready !== 1'b1) begin
      $display("MISMATCH %s: in_ready_o expected 1, actual %b", test_name, in_ready);
      mismatch_count++;
    end
    if (out_valid !== 1'b0) begin
      $display("MISMATCH %s: out_valid_o expected 0, actual %b", test_name, out_valid);
      mismatch_count++;
    end
    if (lane_valid !== 1'b0) begin
      $display("MISMATCH %s: tx_valid_o expected 0, actual %b", test_name, lane_valid);
      mismatch_count++;
    end
  endtask

  task automatic test_single();
    int       out_start;
    int       pulse_start;
    int       pulses;
    payload_t data;
    test_name   = "test_single";
    out_ready   = 1'b1;
    out_start   = out_count;
    pulse_start = pulse_count;
    data        = $random(seed);
    send_payload(data);
    wait_drain();
    wait_quiet();
    if (out_count - out_start != 1) begin
      $display("MISMATCH %s: output count expected 1, actual %0d",
               test_name, out_count - out_start);
      mismatch_count++;
    end
    pulses = pulse_count - pulse_start;
    if (pulses < `SL_FLITS || pulses % `SL_FLITS != 0) begin
      $display("ERROR %s: %0d flit pulses do not form whole packets", test_name, pulses);
      error_count++;
    end
  endtask

  task automatic test_burst();
    int out_start;
    test_name = "test_burst";
    out_ready = 1'b1;
    out_start = out_count;
    for (int i = 0; i < BurstLen; i++) begin
      send_payload($random(seed));
    end
    wait_drain();
    wait_quiet();
    if (out_count - out_start != BurstLen) begin
      $display("MISMATCH %s: output count expected %0d, actual %0d",
               test_name, BurstLen, out_count - out_start);
      mismatch_count++;
    end
  endtask

  // Receive buffer and holding FIFO fill up, then the credits run out
  task automatic test_backpressure();
    int out_start;
    int start_cycle;
    bit saw_ready;
    test_name   = "test_backpressure";
    out_ready   = 1'b0;
    pulse_base  = pulse_count;
    out_start   = out_count;
    start_cycle = cycle_count;
    saw_ready   = 1'b0;
    for (int i = 0; i < BackLen; i++) begin
      send_payload($random(seed));
    end
    if (cycle_count - start_cycle > AcceptLimit) begin
      $display("ERROR %s: accepting %0d payloads took %0d cycles",
               test_name, BackLen, cycle_count - start_cycle);
      error_count++;
    end
    repeat (HoldCycles) begin
      @(posedge clk);
      #1;
      if (in_ready) begin
        saw_ready = 1'b1;
      end
    end
    if (saw_ready) begin
      $display("MISMATCH %s: in_ready_o expected 0, actual 1", test_name);
      mismatch_count++;
    end
    if (out_valid !== 1'b1) begin
      $display("MISMATCH %s: out_valid_o expected 1, actual %b", test_name, out_valid);
      mismatch_count++;
    end
    out_ready = 1'b1;
    wait_drain();
    if (out_count - out_start != BackLen) begin
      $display("MISMATCH %s: output count expected %0d, actual %0d",
               test_name, BackLen, out_count - out_start);
      mismatch_count++;
    end
  endtask

  task automatic test_credit_only();
    int out_start;
    int pulses;
    test_name = "test_credit_only";
    out_start = out_count;
    repeat (IdleCycles) @(posedge clk);
    #1;
    if (out_count != out_start) begin
      $display("MISMATCH %s: output count expected 0, actual %0d",
               test_name, out_count - out_start);
      mismatch_count++;
    end
    wait_quiet();
    pulses = pulse_count - pulse_base;
    if (pulses % `SL_FLITS != 0) begin
      $display("ERROR %s: %0d flit pulses do not form whole packets", test_name, pulses);
      error_count++;
    end
    // Data packets alone would give exactly BackLen packets
    if (pulses <= BackLen * `SL_FLITS) begin
      $display("ERROR %s: no credit-only packet seen on the lanes", test_name);
      error_count++;
    end
  endtask

  initial begin
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    @(posedge rst_n);
    @(posedge clk);
    #1;
    test_reset();
    test_single();
    test_burst();
    test_backpressure();
    test_credit_only();
    print_counts();
    if (mismatch_count == 0 && error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+src
src/serial_link_pkg.sv
src/serial_link_stream_fifo.sv
src/serial_link_credit_ctrl.sv
src/serial_link_data_link.sv
src/serial_link_physical.sv
src/serial_link_top.sv
verif/tb_clk_gen.sv
verif/tb_serial_link.sv

//--- Makefile
# Verilator build and run for the serial link testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_link
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Done: errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
